/* hdl/tlb_pkg.sv */
// TLB shared definitions
// Sizes, page and entry types, and the set/tag split of a virtual page

package tlb_pkg;

    // ======================================================================
    // Sizes
    // ======================================================================

    localparam int VA_PAGE_BITS = 20;
    localparam int PA_PAGE_BITS = 20;
    localparam int NUM_SETS = 64;
    localparam int NUM_WAYS = 4;
    localparam int SET_IDX_BITS = $clog2(NUM_SETS);
    localparam int VA_TAG_BITS = VA_PAGE_BITS - SET_IDX_BITS;
    localparam int WAY_IDX_BITS = $clog2(NUM_WAYS);

    // Request to response, counted in clock edges
    localparam int LOOKUP_LATENCY = 6;
    localparam int FILL_MAX_CYCLES = 6;

    localparam int HIST_ENTRIES = 4;
    localparam int INVAL_HOLD_CYCLES = 8;
    localparam int INVAL_CNT_BITS = $clog2(INVAL_HOLD_CYCLES + 1);

    // Victim selection LFSR, any nonzero seed works
    localparam int RAND_BITS = 8;
    localparam logic [RAND_BITS-1:0] RAND_SEED = 8'hb5;

    // ======================================================================
    // Types
    // ======================================================================

    typedef logic [SET_IDX_BITS-1:0] t_set_idx;
    typedef logic [VA_TAG_BITS-1:0] t_va_tag;
    typedef logic [VA_PAGE_BITS-1:0] t_va_page;
    typedef logic [PA_PAGE_BITS-1:0] t_pa_page;

    // The valid flag stays in bit 0 so that an all-zero word is an empty entry
    typedef struct packed {
        t_va_tag  tag;
        t_pa_page pa_page;
        // Set when the entry caches a failed translation
        logic     not_present;
        logic     valid;
    } t_tlb_entry;

    typedef struct packed {
        t_set_idx   addr;
        t_tlb_entry entry;
    } t_way_write;

    typedef struct packed {
        t_va_page va_page;
        logic     speculative;
    } t_lookup_req;

    typedef struct packed {
        logic     hit;
        logic     miss;
        logic     not_present;
        t_pa_page pa_page;
        t_va_page miss_va;
    } t_lookup_rsp;

    typedef struct packed {
        t_va_page va_page;
        t_pa_page pa_page;
        logic     not_present;
    } t_fill_req;

    // The low bits of a page select the set, the rest form the tag
    function automatic t_set_idx va_set(input t_va_page va);
        return va[SET_IDX_BITS-1:0];
    endfunction

    function automatic t_va_tag va_tag(input t_va_page va);
        return va[VA_PAGE_BITS-1:SET_IDX_BITS];
    endfunction

endpackage

/* hdl/tlb_dup_filter.sv */
// TLB duplicate fill filter
// Short history of inserted pages that rejects a repeated fill

`timescale 1ns/1ps

module tlb_dup_filter
(
    input  logic                clk,
    input  logic                reset,
    input  logic                clear,
    input  logic                check_en,
    input  tlb_pkg::t_va_page   check_page,
    output logic                not_duplicate
);

    logic [tlb_pkg::HIST_ENTRIES-1:0]                     hist_valid;
    tlb_pkg::t_va_page [tlb_pkg::HIST_ENTRIES-1:0]        hist_page;

    // Full page compare covers set and tag together
    logic found;
    always_comb
    begin
        found = 1'b0;
        for (int i = 0; i < tlb_pkg::HIST_ENTRIES; i++)
        begin
            found = found || (hist_valid[i] && (hist_page[i] == check_page));
        end
    end

    // Answer is ready one cycle after check_en
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            not_duplicate <= 1'b0;
        end
        else
        begin
            not_duplicate <= !found;
        end
    end

    logic                check_q;
    tlb_pkg::t_va_page   page_q;

    always_ff @(posedge clk)
    begin
        check_q <= check_en;
        page_q  <= check_page;

        if (check_q && not_duplicate)
        begin
            hist_page <= {hist_page[tlb_pkg::HIST_ENTRIES-2:0], page_q};

            // Older pages of the same set may sit in the way about to be replaced
            for (int i = 0; i < tlb_pkg::HIST_ENTRIES - 1; i++)
            begin
                hist_valid[i+1] <= hist_valid[i] &&
                    (tlb_pkg::va_set(hist_page[i]) != tlb_pkg::va_set(page_q));
            end
            hist_valid[0] <= 1'b1;
        end

        if (reset || clear)
        begin
            check_q    <= 1'b0;
            hist_valid <= '0;
        end
    end

endmodule

/* hdl/tlb_way.sv */
// TLB way
// One way of entry storage with its clear sweep, two-cycle read and split tag compare

`timescale 1ns/1ps

module tlb_way
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  inval_all,
    output logic                  rdy,
    input  tlb_pkg::t_set_idx     raddr,
    input  tlb_pkg::t_va_tag      lookup_tag,
    input  logic                  wen,
    input  tlb_pkg::t_way_write   wr,
    output logic                  match,
    output tlb_pkg::t_tlb_entry   entry
);

    // ======================================================================
    // Storage and clear sweep
    // ======================================================================

    tlb_pkg::t_tlb_entry mem [0:tlb_pkg::NUM_SETS-1];

    logic              inval_q;
    logic              sweeping;
    tlb_pkg::t_set_idx clr_idx;

    // The sweep walks every set once, starting one cycle after inval_all
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            inval_q <= 1'b0;
        end
        else
        begin
            inval_q <= inval_all;
        end

        if (reset || inval_q)
        begin
            sweeping <= 1'b1;
            clr_idx  <= '0;
            rdy      <= 1'b0;
        end
        else
        begin
            // Ready one cycle after the last set is cleared
            rdy <= ~sweeping;
            if (sweeping)
            begin
                clr_idx <= clr_idx + 1'b1;
                if (clr_idx == tlb_pkg::t_set_idx'(tlb_pkg::NUM_SETS - 1))
                begin
                    sweeping <= 1'b0;
                end
            end
        end
    end

    // Single write port, the sweep wins over a normal write
    always_ff @(posedge clk)
    begin
        if (sweeping)
        begin
            mem[clr_idx] <= '0;
        end
        else if (wen)
        begin
            mem[wr.addr] <= wr.entry;
        end
    end

    // ======================================================================
    // Read pipeline and tag compare
    // ======================================================================

    tlb_pkg::t_tlb_entry rd_q1;
    tlb_pkg::t_tlb_entry rd_q2;
    tlb_pkg::t_va_tag    tag_q1;
    tlb_pkg::t_va_tag    tag_q2;
    tlb_pkg::t_va_tag    xor_q3;
    tlb_pkg::t_tlb_entry entry_q3;

    always_ff @(posedge clk)
    begin
        // Stages 1 and 2 model a block RAM with an output register
        rd_q1  <= mem[raddr];
        rd_q2  <= rd_q1;
        tag_q1 <= lookup_tag;
        tag_q2 <= tag_q1;

        // Stage 3 keeps the tag difference as a vector
        xor_q3   <= rd_q2.tag ^ tag_q2;
        entry_q3 <= rd_q2;

        // Stage 4 reduces it, a match needs zero difference and a valid entry
        match <= entry_q3.valid && ~(|xor_q3);
        entry <= entry_q3;
    end

endmodule

/* hdl/tlb_hit_select.sv */
// TLB hit select
// Gathers the way compare results and builds the registered lookup response

`timescale 1ns/1ps

module tlb_hit_select
(
    input  logic                                             clk,
    input  logic                                             reset,
    input  logic                                             lookup_en,
    input  tlb_pkg::t_lookup_req                             lookup_req,
    input  logic [tlb_pkg::NUM_WAYS-1:0]                     match,
    input  tlb_pkg::t_tlb_entry [tlb_pkg::NUM_WAYS-1:0]      entry,
    output tlb_pkg::t_lookup_rsp                             lookup_rsp
);

    localparam int LAST_STG = tlb_pkg::LOOKUP_LATENCY - 1;

    // ======================================================================
    // Request flags travel beside the way pipelines
    // ======================================================================

    // Index k holds the request that entered k edges ago
    logic [LAST_STG-1:1]                      did_q;
    tlb_pkg::t_lookup_req [LAST_STG:1]        req_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            did_q <= '0;
        end
        else
        begin
            did_q <= {did_q[LAST_STG-2:1], lookup_en};
        end
        req_q <= {req_q[LAST_STG-1:1], lookup_req};
    end

    // ======================================================================
    // Stage 4 way choice
    // ======================================================================

    logic                                any_hit;
    logic [tlb_pkg::WAY_IDX_BITS-1:0]    hit_way;

    // Scanning downward leaves the lowest matching way selected
    always_comb
    begin
        any_hit = |match;
        hit_way = '0;
        for (int w = tlb_pkg::NUM_WAYS - 1; w >= 0; w--)
        begin
            if (match[w])
            begin
                hit_way = tlb_pkg::WAY_IDX_BITS'(w);
            end
        end
    end

    logic                hit_q;
    logic                miss_q;
    tlb_pkg::t_pa_page   pa_q;
    logic                np_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            hit_q  <= 1'b0;
            miss_q <= 1'b0;
        end
        else
        begin
            hit_q  <= did_q[4] && any_hit;
            miss_q <= did_q[4] && !any_hit;
        end
        pa_q <= entry[hit_way].pa_page;
        np_q <= entry[hit_way].not_present;
    end

    // ======================================================================
    // Final register with the not-present rule
    // ======================================================================

    // A cached failure counts as a hit only for speculative lookups
    logic np_as_miss;
    assign np_as_miss = np_q && !req_q[LAST_STG].speculative;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lookup_rsp.hit  <= 1'b0;
            lookup_rsp.miss <= 1'b0;
        end
        else
        begin
            lookup_rsp.hit  <= hit_q && !np_as_miss;
            lookup_rsp.miss <= miss_q || (hit_q && np_as_miss);
        end
        lookup_rsp.not_present <= np_q;
        lookup_rsp.pa_page     <= pa_q;
        lookup_rsp.miss_va     <= req_q[LAST_STG].va_page;
    end

endmodule

/* hdl/tlb_fill_ctrl.sv */
// TLB fill controller
// Accepts walker fills, filters duplicates, picks a victim way and drives the way writes

`timescale 1ns/1ps

module tlb_fill_ctrl
(
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           fill_en,
    input  tlb_pkg::t_fill_req             fill_req,
    input  logic                           inval_page_en,
    input  tlb_pkg::t_va_page              inval_page,
    input  logic                           inval_all,
    output logic [tlb_pkg::NUM_WAYS-1:0]   wen,
    output tlb_pkg::t_way_write            wr
);

    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_CHECK,
        FILL_DECIDE,
        FILL_INSERT
    } t_fill_state;

    t_fill_state                          state;
    tlb_pkg::t_fill_req                   fill_q;
    logic [tlb_pkg::NUM_WAYS-1:0]         victim_vec;
    logic [tlb_pkg::RAND_BITS-1:0]        lfsr;
    logic [tlb_pkg::INVAL_CNT_BITS-1:0]   hold_cnt;
    logic                                 hold_fill;
    logic                                 not_duplicate;

    // ======================================================================
    // Page invalidation drain window
    // ======================================================================

    // Fills stay blocked while the counter runs so in-flight ones drain out
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            hold_cnt <= '0;
        end
        else if (inval_page_en)
        begin
            hold_cnt <= tlb_pkg::INVAL_CNT_BITS'(tlb_pkg::INVAL_HOLD_CYCLES);
        end
        else if (hold_cnt != '0)
        begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    assign hold_fill = inval_page_en || (hold_cnt != '0);

    // ======================================================================
    // Fill state machine
    // ======================================================================

    tlb_dup_filter u_dup_filter
    (
        .clk           (clk),
        .reset         (reset),
        .clear         (inval_all || inval_page_en),
        .check_en      (state == FILL_CHECK),
        .check_page    (fill_q.va_page),
        .not_duplicate (not_duplicate)
    );

    // Only an idle controller takes a fill, the walker simply retries later
    always_ff @(posedge clk)
    begin
        if (reset || inval_all || hold_fill)
        begin
            state <= FILL_IDLE;
        end
        else
        begin
            case (state)
                FILL_IDLE:
                begin
                    if (fill_en)
                    begin
                        state <= FILL_CHECK;
                    end
                end
                FILL_CHECK:
                begin
                    state <= FILL_DECIDE;
                end
                FILL_DECIDE:
                begin
                    // A recent duplicate is already in the TLB
                    state <= not_duplicate ? FILL_INSERT : FILL_IDLE;
                end
                default:
                begin
                    state <= FILL_IDLE;
                end
            endcase
        end
    end

    // Free-running LFSR, x^8 + x^6 + x^5 + x^4 + 1
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lfsr <= tlb_pkg::RAND_SEED;
        end
        else
        begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    always_ff @(posedge clk)
    begin
        if ((state == FILL_IDLE) && fill_en)
        begin
            fill_q <= fill_req;
        end
        if (state == FILL_DECIDE)
        begin
            victim_vec <= tlb_pkg::NUM_WAYS'(1) << lfsr[tlb_pkg::WAY_IDX_BITS-1:0];
        end
    end

    // ======================================================================
    // Write port shared by all ways
    // ======================================================================

    // Invalidation hits every way of the set and overrides a pending insert
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wen <= '0;
        end
        else if (inval_page_en)
        begin
            wen <= '1;
        end
        else if (state == FILL_INSERT)
        begin
            wen <= victim_vec;
        end
        else
        begin
            wen <= '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (inval_page_en)
        begin
            wr.addr  <= tlb_pkg::va_set(inval_page);
            wr.entry <= '0;
        end
        else
        begin
            wr.addr              <= tlb_pkg::va_set(fill_q.va_page);
            wr.entry.tag         <= tlb_pkg::va_tag(fill_q.va_page);
            wr.entry.pa_page     <= fill_q.pa_page;
            wr.entry.not_present <= fill_q.not_present;
            wr.entry.valid       <= 1'b1;
        end
    end

endmodule

/* hdl/tlb_top.sv */
// TLB top level
// Fill controller, the set-associative ways and the hit selector

`timescale 1ns/1ps

module tlb_top
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   lookup_en,
    input  tlb_pkg::t_lookup_req   lookup_req,
    output logic                   lookup_rdy,
    output tlb_pkg::t_lookup_rsp   lookup_rsp,
    input  logic                   fill_en,
    input  tlb_pkg::t_fill_req     fill_req,
    input  logic                   inval_page_en,
    input  tlb_pkg::t_va_page      inval_page,
    input  logic                   inval_all
);

    logic [tlb_pkg::NUM_WAYS-1:0]                    way_wen;
    tlb_pkg::t_way_write                             way_wr;
    logic [tlb_pkg::NUM_WAYS-1:0]                    way_rdy;
    logic [tlb_pkg::NUM_WAYS-1:0]                    way_match;
    tlb_pkg::t_tlb_entry [tlb_pkg::NUM_WAYS-1:0]     way_entry;
    tlb_pkg::t_set_idx                               rd_set;
    tlb_pkg::t_va_tag                                rd_tag;

    // Every way reads the same set and compares the same tag
    assign rd_set = tlb_pkg::va_set(lookup_req.va_page);
    assign rd_tag = tlb_pkg::va_tag(lookup_req.va_page);

    // All ways sweep in lockstep, so way 0 speaks for the set
    assign lookup_rdy = way_rdy[0];

    tlb_fill_ctrl u_fill_ctrl
    (
        .clk           (clk),
        .reset         (reset),
        .fill_en       (fill_en),
        .fill_req      (fill_req),
        .inval_page_en (inval_page_en),
        .inval_page    (inval_page),
        .inval_all     (inval_all),
        .wen           (way_wen),
        .wr            (way_wr)
    );

    for (genvar w = 0; w < tlb_pkg::NUM_WAYS; w++)
    begin : g_way
        tlb_way u_way
        (
            .clk        (clk),
            .reset      (reset),
            .inval_all  (inval_all),
            .rdy        (way_rdy[w]),
            .raddr      (rd_set),
            .lookup_tag (rd_tag),
            .wen        (way_wen[w]),
            .wr         (way_wr),
            .match      (way_match[w]),
            .entry      (way_entry[w])
        );
    end

    tlb_hit_select u_hit_select
    (
        .clk        (clk),
        .reset      (reset),
        .lookup_en  (lookup_en),
        .lookup_req (lookup_req),
        .match      (way_match),
        .entry      (way_entry),
        .lookup_rsp (lookup_rsp)
    );

endmodule

/* verif/tlb_asserts.sv */
// TLB protocol assertions
// Watches the response strobes, the lookup gating and the way write enables

`timescale 1ns/1ps

module tlb_asserts
(
    input logic                           clk,
    input logic                           reset,
    input logic                           lookup_en,
    input logic                           lookup_rdy,
    input tlb_pkg::t_lookup_rsp           lookup_rsp,
    input logic [tlb_pkg::NUM_WAYS-1:0]   wen
);

    // Number of assertion failures seen so far
    int fail_count = 0;

    // A response is either a hit or a miss, never both
    hit_miss_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(lookup_rsp.hit && lookup_rsp.miss))
    else
    begin
        $error("lookup response raised hit and miss in the same cycle");
        fail_count = fail_count + 1;
    end

    // The pipeline has no back-pressure, so the client must wait for ready
    lookup_gated: assert property (@(posedge clk) disable iff (reset)
        lookup_en |-> lookup_rdy)
    else
    begin
        $error("lookup issued while lookup_rdy was low");
        fail_count = fail_count + 1;
    end

    // A fill writes one victim way, a page invalidation writes every way
    wen_shape: assert property (@(posedge clk) disable iff (reset)
        (wen == '0) || $onehot(wen) || (&wen))
    else
    begin
        $error("way write enables are neither one-hot nor all set");
        fail_count = fail_count + 1;
    end

endmodule

bind tlb_top tlb_asserts u_asserts
(
    .clk        (clk),
    .reset      (reset),
    .lookup_en  (lookup_en),
    .lookup_rdy (lookup_rdy),
    .lookup_rsp (lookup_rsp),
    .wen        (way_wen)
);

/* verif/tlb_tb.sv */
// TLB testbench
// Drives lookups, fills and invalidations and checks every response against a reference model

`timescale 1ns/1ps

module tlb_tb;

    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 16;
    localparam int FILL_WAIT = tlb_pkg::FILL_MAX_CYCLES + 2;
    localparam int RDY_TIMEOUT = tlb_pkg::NUM_SETS + 16;
    localparam int DRAIN_TIMEOUT = tlb_pkg::LOOKUP_LATENCY + 8;
    localparam int SET_BITS = tlb_pkg::SET_IDX_BITS;

    // One slot of the duplicate history as the reference sees it
    typedef struct packed {
        logic              valid;
        tlb_pkg::t_va_page page;
    } t_hist_slot;

    logic                   clk;
    logic                   reset;
    logic                   lookup_en;
    tlb_pkg::t_lookup_req   lookup_req;
    logic                   lookup_rdy;
    tlb_pkg::t_lookup_rsp   lookup_rsp;
    logic                   fill_en;
    tlb_pkg::t_fill_req     fill_req;
    logic                   inval_page_en;
    tlb_pkg::t_va_page      inval_page;
    logic                   inval_all;

    tlb_top uut
    (
        .clk           (clk),
        .reset         (reset),
        .lookup_en     (lookup_en),
        .lookup_req    (lookup_req),
        .lookup_rdy    (lookup_rdy),
        .lookup_rsp    (lookup_rsp),
        .fill_en       (fill_en),
        .fill_req      (fill_req),
        .inval_page_en (inval_page_en),
        .inval_page    (inval_page),
        .inval_all     (inval_all)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Counts rising edges to time each response
    int cyc = 0;
    always @(posedge clk)
    begin
        cyc <= cyc + 1;
    end

    // ======================================================================
    // Reference model
    // ======================================================================

    tlb_pkg::t_fill_req     ref_map [tlb_pkg::t_va_page];
    t_hist_slot             hist_q [$];
    tlb_pkg::t_lookup_rsp   exp_q [$];
    int                     due_q [$];
    int                     errors = 0;
    int                     checks = 0;
    int                     passed = 0;
    logic [31:0]            rng_state = 32'h456a;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // Places the tag in the upper bits and the set index in the low SET_BITS
    function automatic tlb_pkg::t_va_page make_page(input int set, input logic [31:0] rnd);
        tlb_pkg::t_va_tag tag;
        tag = tlb_pkg::t_va_tag'(rnd);
        return {tag, SET_BITS'(set)};
    endfunction

    // Expected response for one lookup against the current model state
    function automatic tlb_pkg::t_lookup_rsp ref_lookup(input tlb_pkg::t_lookup_req req);
        tlb_pkg::t_lookup_rsp rsp;
        rsp = '0;
        rsp.miss_va = req.va_page;
        // A cached failure only counts as a hit when the lookup is speculative
        if (ref_map.exists(req.va_page) &&
            (!ref_map[req.va_page].not_present || req.speculative))
        begin
            rsp.hit         = 1'b1;
            rsp.pa_page     = ref_map[req.va_page].pa_page;
            rsp.not_present = ref_map[req.va_page].not_present;
        end
        else
        begin
            rsp.miss = 1'b1;
        end
        return rsp;
    endfunction

    // Models an accepted fill and drops it when it repeats a recent page
    function automatic void model_fill(input tlb_pkg::t_fill_req req);
        t_hist_slot slot;
        foreach (hist_q[i])
        begin
            if (hist_q[i].valid && (hist_q[i].page == req.va_page))
            begin
                return;
            end
        end
        // Older pages of the same set no longer count as recent
        foreach (hist_q[i])
        begin
            if (hist_q[i].page[SET_BITS-1:0] == req.va_page[SET_BITS-1:0])
            begin
                hist_q[i].valid = 1'b0;
            end
        end
        slot.valid = 1'b1;
        slot.page  = req.va_page;
        hist_q.push_front(slot);
        if (hist_q.size() > tlb_pkg::HIST_ENTRIES)
        begin
            void'(hist_q.pop_back());
        end
        ref_map[req.va_page] = req;
    endfunction

    // Every way of the set is cleared
    function automatic void model_inval_page(input tlb_pkg::t_va_page page);
        tlb_pkg::t_va_page victims [$];
        foreach (ref_map[key])
        begin
            if (key[SET_BITS-1:0] == page[SET_BITS-1:0])
            begin
                victims.push_back(key);
            end
        end
        foreach (victims[i])
        begin
            ref_map.delete(victims[i]);
        end
        hist_q.delete();
    endfunction

    // ======================================================================
    // Checking
    // ======================================================================

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        if (got !== want)
        begin
            $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, want);
            errors++;
        end
    endtask

    // Responses are sampled on the falling edge half a cycle after they settle
    always @(negedge clk)
    begin : compare_rsp
        tlb_pkg::t_lookup_rsp want;
        int                   due;
        if (!reset && ((lookup_rsp.hit === 1'b1) || (lookup_rsp.miss === 1'b1)))
        begin
            if (exp_q.size() == 0)
            begin
                $display("lookup response arrived with no lookup outstanding");
                errors++;
            end
            else
            begin
                want = exp_q.pop_front();
                due  = due_q.pop_front();
                check_value("response cycle", cyc, due);
                check_value("lookup_rsp.hit", lookup_rsp.hit, want.hit);
                check_value("lookup_rsp.miss", lookup_rsp.miss, want.miss);
                check_value("lookup_rsp.miss_va", lookup_rsp.miss_va, want.miss_va);
                if (want.hit)
                begin
                    check_value("lookup_rsp.pa_page", lookup_rsp.pa_page, want.pa_page);
                    check_value("lookup_rsp.not_present", lookup_rsp.not_present,
                                want.not_present);
                end
            end
        end
    end

    // ======================================================================
    // Stimulus tasks
    // ======================================================================

    task automatic wait_rdy(input logic level);
        int n;
        n = 0;
        while ((lookup_rdy !== level) && (n < RDY_TIMEOUT))
        begin
            @(negedge clk);
            n++;
        end
        if (lookup_rdy !== level)
        begin
            $display("lookup_rdy did not reach %0d within %0d cycles", level, RDY_TIMEOUT);
            errors++;
        end
    endtask

    task automatic do_fill(input tlb_pkg::t_va_page va, input tlb_pkg::t_pa_page pa,
                           input logic np, input logic accepted);
        tlb_pkg::t_fill_req req;
        req.va_page     = va;
        req.pa_page     = pa;
        req.not_present = np;
        @(posedge clk);
        fill_en  <= 1'b1;
        fill_req <= req;
        @(posedge clk);
        fill_en <= 1'b0;
        // A fill sent into the drain window never reaches the model
        if (accepted)
        begin
            model_fill(req);
        end
    endtask

    task automatic issue_lookup(input tlb_pkg::t_va_page va, input logic spec);
        tlb_pkg::t_lookup_req req;
        req.va_page     = va;
        req.speculative = spec;
        @(posedge clk);
        lookup_en  <= 1'b1;
        lookup_req <= req;
        exp_q.push_back(ref_lookup(req));
        // cyc still holds the count before this edge
        due_q.push_back(cyc + 1 + tlb_pkg::LOOKUP_LATENCY);
    endtask

    // Stops issuing and waits until every outstanding response came back
    task automatic end_lookups();
        int n;
        @(posedge clk);
        lookup_en <= 1'b0;
        n = 0;
        while ((exp_q.size() != 0) && (n < DRAIN_TIMEOUT))
        begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0)
        begin
            $display("%0d lookup responses never arrived", exp_q.size());
            errors++;
            exp_q.delete();
            due_q.delete();
        end
    endtask

    task automatic finish_test(input int num, input string name, input int errs_before);
        if (errors == errs_before)
        begin
            $display("test %0d %s: ok", num, name);
            passed++;
        end
        else
        begin
            $display("test %0d %s: %0d errors", num, name, errors - errs_before);
        end
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial
    begin
        tlb_pkg::t_va_page pages [$];
        tlb_pkg::t_va_page filled [$];
        tlb_pkg::t_va_page pg;
        tlb_pkg::t_pa_page pa;
        int                e;
        int                asrt;

        reset         = 1'b1;
        lookup_en     = 1'b0;
        lookup_req    = '0;
        fill_en       = 1'b0;
        fill_req      = '0;
        inval_page_en = 1'b0;
        inval_page    = '0;
        inval_all     = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // Test 1 waits out the clear sweep, then an empty TLB misses everywhere
        e = errors;
        wait_rdy(1'b1);
        for (int i = 0; i < 8; i++)
        begin
            issue_lookup(tlb_pkg::t_va_page'(next_rand()), i[0]);
        end
        end_lookups();
        finish_test(1, "cold misses", e);

        // Test 2 fills sets 0 to 7 and reads them back one per cycle
        e = errors;
        for (int s = 0; s < 8; s++)
        begin
            pg = make_page(s, next_rand());
            pages.push_back(pg);
            filled.push_back(pg);
            do_fill(pg, tlb_pkg::t_pa_page'(next_rand()), 1'b0, 1'b1);
            repeat (FILL_WAIT) @(posedge clk);
        end
        foreach (pages[i])
        begin
            issue_lookup(pages[i], i[0]);
        end
        end_lookups();
        finish_test(2, "fill and hit", e);

        // Test 3 caches a failed translation in set 8
        e = errors;
        pg = make_page(8, next_rand());
        filled.push_back(pg);
        do_fill(pg, tlb_pkg::t_pa_page'(next_rand()), 1'b1, 1'b1);
        repeat (FILL_WAIT) @(posedge clk);
        issue_lookup(pg, 1'b1);
        issue_lookup(pg, 1'b0);
        end_lookups();
        finish_test(3, "not present", e);

        // Test 4 repeats a fill in set 9 with another physical page
        e = errors;
        pg = make_page(9, next_rand());
        pa = tlb_pkg::t_pa_page'(next_rand());
        filled.push_back(pg);
        do_fill(pg, pa, 1'b0, 1'b1);
        repeat (FILL_WAIT) @(posedge clk);
        do_fill(pg, ~pa, 1'b0, 1'b1);
        repeat (FILL_WAIT) @(posedge clk);
        issue_lookup(pg, 1'b0);
        issue_lookup(pg, 1'b1);
        end_lookups();
        finish_test(4, "duplicate fill", e);

        // Test 5 drops set 3 and sends a set 10 fill into the drain window
        e = errors;
        @(posedge clk);
        inval_page_en <= 1'b1;
        inval_page    <= pages[3];
        @(posedge clk);
        inval_page_en <= 1'b0;
        model_inval_page(pages[3]);
        pg = make_page(10, next_rand());
        filled.push_back(pg);
        do_fill(pg, tlb_pkg::t_pa_page'(next_rand()), 1'b0, 1'b0);
        repeat (tlb_pkg::INVAL_HOLD_CYCLES + FILL_WAIT) @(posedge clk);
        foreach (pages[i])
        begin
            issue_lookup(pages[i], 1'b0);
        end
        issue_lookup(pg, 1'b0);
        end_lookups();
        finish_test(5, "page invalidation", e);

        // Test 6 clears the whole TLB and rechecks every page ever filled
        // Speculative lookups would also expose a surviving not-present entry
        e = errors;
        @(posedge clk);
        inval_all <= 1'b1;
        @(posedge clk);
        inval_all <= 1'b0;
        ref_map.delete();
        hist_q.delete();
        wait_rdy(1'b0);
        wait_rdy(1'b1);
        foreach (filled[i])
        begin
            issue_lookup(filled[i], 1'b1);
        end
        end_lookups();
        finish_test(6, "full invalidation", e);

        repeat (4) @(posedge clk);
        asrt   = uut.u_asserts.fail_count;
        errors = errors + asrt;
        $display("tests passed %0d of 6, checks %0d, errors %0d, assertion failures %0d",
                 passed, checks, errors, asrt);
        if (errors == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* tb.f */
hdl/tlb_pkg.sv
hdl/tlb_dup_filter.sv
hdl/tlb_way.sv
hdl/tlb_hit_select.sv
hdl/tlb_fill_ctrl.sv
hdl/tlb_top.sv
verif/tlb_asserts.sv
verif/tlb_tb.sv
